// File: Bender.yml
package:
  name: dhcp_rx

sources:
  - files:
      - common/udp_rx_pkg.sv
      - common/dhcp_rx_pkg.sv
      - hw/udp_port_filter.sv
      - hw/rx_byte_fifo.sv
      - dhcp_rx/dhcp_opt_parser.sv
      - hw/dhcp_rx_top.sv
  - target: test
    files:
      - dv/dhcp_rx_sva.sv
      - dv/dhcp_rx_tb.sv

// File: common/dhcp_rx_pkg.sv
package dhcp_rx_pkg;

  // server to client direction only
  localparam udp_rx_pkg::port_t DHCP_SRV_PORT = 16'd67;
  localparam udp_rx_pkg::port_t DHCP_CLI_PORT = 16'd68;

  // fixed bootp header, magic cookie included
  localparam int DHCP_HDR_LEN = 240;
  localparam int XID_OFS      = 4;
  localparam int YIADDR_OFS   = 16;

  localparam logic [31:0] MAGIC_COOKIE = 32'h63825363;

  // option codes the parser knows about
  localparam logic [7:0] OPT_PAD        = 8'd0;
  localparam logic [7:0] OPT_NET_MASK   = 8'd1;
  localparam logic [7:0] OPT_ROUTER     = 8'd3;
  localparam logic [7:0] OPT_DNS        = 8'd6;
  localparam logic [7:0] OPT_LEASE_TIME = 8'd51;
  localparam logic [7:0] OPT_MSG_TYPE   = 8'd53;
  localparam logic [7:0] OPT_SRV_ID     = 8'd54;
  localparam logic [7:0] OPT_END        = 8'd255;

  typedef logic [31:0] ipv4_t;
  typedef logic [31:0] xid_t;
  typedef logic [31:0] lease_t;
  typedef logic [7:0]  msg_type_t;

  // byte index inside the bootp header
  typedef logic [$clog2(DHCP_HDR_LEN)-1:0] hdr_idx_t;

  // presence bitmap, bit 0 is msg type and bit 5 is lease
  typedef logic [5:0] opt_pres_t;

  localparam int PRES_MSG_TYPE = 0;
  localparam int PRES_MASK     = 1;
  localparam int PRES_ROUTER   = 2;
  localparam int PRES_DNS      = 3;
  localparam int PRES_SRV_ID   = 4;
  localparam int PRES_LEASE    = 5;

  typedef enum logic [2:0] {
    PS_HDR,
    PS_KIND,
    PS_LEN,
    PS_DATA,
    PS_HOLD,
    PS_SKIP
  } parse_state_t;

endpackage : dhcp_rx_pkg

// File: common/udp_rx_pkg.sv
package udp_rx_pkg;

  // one byte of the udp payload stream
  typedef logic [7:0] byte_t;

  // udp port number as seen in the udp header
  typedef logic [15:0] port_t;

  // byte fifo between the port filter and the option parser
  // depth must be a power of two, 4 or more
  localparam int FIFO_DEPTH = 16;
  localparam int FIFO_AW    = $clog2(FIFO_DEPTH);

  // fifo entry holds the byte plus its sof and eof flags
  localparam int FIFO_EW = $bits(byte_t) + 2;

  typedef logic [FIFO_EW-1:0] fifo_ent_t;

  // pointers carry one extra wrap bit
  typedef logic [FIFO_AW:0] fifo_ptr_t;

endpackage : udp_rx_pkg

// File: dhcp_rx/dhcp_opt_parser.sv
`timescale 1ns/1ps

module dhcp_opt_parser (
  input  logic                    clk,
  input  logic                    fsm_rst,
  input  udp_rx_pkg::byte_t       rd_dat,
  input  logic                    rd_sof,
  input  logic                    rd_eof,
  input  logic                    rd_val,
  output logic                    rd_en,
  input  logic                    res_rdy,
  output logic                    res_val,
  output logic                    res_err,
  output dhcp_rx_pkg::msg_type_t  res_msg_type,
  output dhcp_rx_pkg::xid_t       res_xid,
  output dhcp_rx_pkg::ipv4_t      res_yiaddr,
  output dhcp_rx_pkg::ipv4_t      res_mask,
  output dhcp_rx_pkg::ipv4_t      res_router,
  output dhcp_rx_pkg::ipv4_t      res_dns,
  output dhcp_rx_pkg::ipv4_t      res_srv_id,
  output dhcp_rx_pkg::lease_t     res_lease,
  output dhcp_rx_pkg::opt_pres_t  res_pres
);

  import udp_rx_pkg::*;
  import dhcp_rx_pkg::*;

  parse_state_t state;

  hdr_idx_t  hdr_cnt;
  hdr_idx_t  hdr_idx;
  byte_t     opt_len;
  byte_t     opt_cnt;
  byte_t     last_idx;
  opt_pres_t opt_sel;

  logic [31:0] win;
  logic [31:0] opt_word;

  logic take;
  logic hdr_live;
  logic frame_cut;

  // one-hot presence bit for an option code, zero when unknown
  function automatic opt_pres_t opt_mask(input byte_t code);
    opt_pres_t m;
    m = '0;
    case (code)
      OPT_MSG_TYPE:   m[PRES_MSG_TYPE] = 1'b1;
      OPT_NET_MASK:   m[PRES_MASK]     = 1'b1;
      OPT_ROUTER:     m[PRES_ROUTER]   = 1'b1;
      OPT_DNS:        m[PRES_DNS]      = 1'b1;
      OPT_SRV_ID:     m[PRES_SRV_ID]   = 1'b1;
      OPT_LEASE_TIME: m[PRES_LEASE]    = 1'b1;
      default: ;
    endcase
    return m;
  endfunction

  assign rd_en = rd_val && (state != PS_HOLD);
  assign take  = rd_en;

  assign opt_word = {win[23:0], rd_dat};

  // bytes before the first sof are dropped
  assign hdr_live = rd_sof || (hdr_cnt != '0);
  assign hdr_idx  = rd_sof ? '0 : hdr_cnt;

  // only the first four data bytes of an option are kept
  assign last_idx = (opt_len > 8'd4) ? 8'd3 : opt_len - 8'd1;

  // eof anywhere before END closes the frame with an error
  assign frame_cut = take && rd_eof &&
                     (((state == PS_HDR) && hdr_live) ||
                      ((state == PS_KIND) && (rd_dat != OPT_END)) ||
                      (state == PS_LEN) || (state == PS_DATA));

  always_ff @ (posedge clk) begin
    if (fsm_rst) begin
      state   <= PS_HDR;
      hdr_cnt <= '0;
      res_val <= 1'b0;
    end
    else begin
      if (res_val && res_rdy) begin
        res_val <= 1'b0;
      end

      case (state)
        PS_HDR: begin
          if (take && hdr_live) begin
            win <= opt_word;
            if (rd_sof) begin
              res_err      <= 1'b0;
              res_pres     <= '0;
              res_msg_type <= '0;
              res_xid      <= '0;
              res_yiaddr   <= '0;
              res_mask     <= '0;
              res_router   <= '0;
              res_dns      <= '0;
              res_srv_id   <= '0;
              res_lease    <= '0;
            end
            if (hdr_idx == XID_OFS + 3) begin
              res_xid <= opt_word;
            end
            if (hdr_idx == YIADDR_OFS + 3) begin
              res_yiaddr <= opt_word;
            end
            if (hdr_idx == DHCP_HDR_LEN - 1) begin
              // a bad cookie is reported but the options are still walked
              if (opt_word != MAGIC_COOKIE) begin
                res_err <= 1'b1;
              end
              hdr_cnt <= '0;
              state   <= PS_KIND;
            end
            else begin
              hdr_cnt <= hdr_idx + 1'b1;
            end
          end
        end

        PS_KIND: begin
          if (take) begin
            if (rd_dat == OPT_END) begin
              res_val <= 1'b1;
              state   <= rd_eof ? PS_HOLD : PS_SKIP;
            end
            else if (rd_dat != OPT_PAD) begin
              opt_sel  <= opt_mask(rd_dat);
              res_pres <= res_pres | opt_mask(rd_dat);
              state    <= PS_LEN;
            end
          end
        end

        PS_LEN: begin
          if (take) begin
            opt_len <= rd_dat;
            opt_cnt <= '0;
            win     <= '0;
            state   <= (rd_dat == 8'd0) ? PS_KIND : PS_DATA;
          end
        end

        PS_DATA: begin
          if (take) begin
            if (opt_cnt < 8'd4) begin
              win <= opt_word;
            end
            if (opt_cnt == last_idx) begin
              if (opt_sel[PRES_MSG_TYPE]) res_msg_type <= opt_word[7:0];
              if (opt_sel[PRES_MASK])     res_mask     <= opt_word;
              if (opt_sel[PRES_ROUTER])   res_router   <= opt_word;
              if (opt_sel[PRES_DNS])      res_dns      <= opt_word;
              if (opt_sel[PRES_SRV_ID])   res_srv_id   <= opt_word;
              if (opt_sel[PRES_LEASE])    res_lease    <= opt_word;
            end
            opt_cnt <= opt_cnt + 8'd1;
            if (opt_cnt == opt_len - 8'd1) begin
              state <= PS_KIND;
            end
          end
        end

        // drain whatever follows END, the result is already out
        PS_SKIP: begin
          if (take && rd_eof) begin
            state <= (res_val && !res_rdy) ? PS_HOLD : PS_HDR;
          end
        end

        PS_HOLD: begin
          if (res_rdy) begin
            state <= PS_HDR;
          end
        end

        default: state <= PS_HDR;
      endcase

      if (frame_cut) begin
        res_val <= 1'b1;
        res_err <= 1'b1;
        hdr_cnt <= '0;
        state   <= PS_HOLD;
      end
    end
  end

endmodule : dhcp_opt_parser

// File: dv/dhcp_rx_sva.sv
`timescale 1ns/1ps

module dhcp_rx_sva (
  input logic                  clk,
  input logic                  fsm_rst,
  input logic                  wr_en,
  input udp_rx_pkg::fifo_ptr_t fill,
  input logic                  res_val,
  input logic                  res_rdy,
  input logic [238:0]          res_bus
);

  import udp_rx_pkg::*;

  int fail_cnt = 0;

  // a waiting result must not move
  a_res_hold: assert property (@(posedge clk) disable iff (fsm_rst)
    res_val && !res_rdy |=> res_val && $stable(res_bus))
    else begin
      fail_cnt++;
      $error("result changed while res_rdy was low");
    end

  a_no_overflow: assert property (@(posedge clk) disable iff (fsm_rst)
    wr_en |-> fill < FIFO_DEPTH)
    else begin
      fail_cnt++;
      $error("write into a full fifo");
    end

  a_rst_idle: assert property (@(posedge clk) fsm_rst |=> !res_val)
    else begin
      fail_cnt++;
      $error("res_val high right after reset");
    end

endmodule : dhcp_rx_sva

bind dhcp_opt_parser dhcp_rx_sva i_parser_sva (
  .clk     (clk),
  .fsm_rst (fsm_rst),
  .wr_en   (1'b0),
  .fill    ('0),
  .res_val (res_val),
  .res_rdy (res_rdy),
  .res_bus ({res_err, res_msg_type, res_xid, res_yiaddr, res_mask,
             res_router, res_dns, res_srv_id, res_lease, res_pres})
);

bind rx_byte_fifo dhcp_rx_sva i_fifo_sva (
  .clk     (clk),
  .fsm_rst (fsm_rst),
  .wr_en   (wr_en),
  .fill    (fill),
  .res_val (1'b0),
  .res_rdy (1'b0),
  .res_bus ('0)
);

// File: dv/dhcp_rx_tb.sv
`timescale 1ns/1ps

module dhcp_rx_tb;

  import udp_rx_pkg::*;
  import dhcp_rx_pkg::*;

  localparam int N_ROWS   = 9;
  localparam int N_FREE   = 6;
  localparam int WAIT_MAX = 3000;

  // one frame with its stimulus and the record it should produce
  typedef struct packed {
    port_t     sp;
    port_t     dp;
    xid_t      xid;
    ipv4_t     yiaddr;
    logic      bad_cookie;
    logic      trunc;
    logic      junk;
    opt_pres_t pres;
    msg_type_t mt;
    ipv4_t     mask;
    ipv4_t     router;
    ipv4_t     dns;
    ipv4_t     srv_id;
    lease_t    lease;
  } row_t;

  logic      clk = 1'b0;
  logic      fsm_rst;
  byte_t     in_dat;
  logic      in_val;
  logic      in_sof;
  logic      in_eof;
  port_t     src_port;
  port_t     dst_port;
  logic      in_rdy;
  logic      res_rdy;
  logic      res_val;
  logic      res_err;
  msg_type_t res_msg_type;
  xid_t      res_xid;
  ipv4_t     res_yiaddr;
  ipv4_t     res_mask;
  ipv4_t     res_router;
  ipv4_t     res_dns;
  ipv4_t     res_srv_id;
  lease_t    res_lease;
  opt_pres_t res_pres;

  row_t        table_rows [N_ROWS];
  row_t        exp_q [$];
  byte_t       frame [$];
  logic [31:0] tx_lfsr;
  logic [31:0] rx_lfsr;
  logic        hold_res;
  logic        timed_out;
  int          errors;
  int          checks;

  dhcp_rx_top i_dhcp_rx_top (.*);

  initial begin
    forever #50 clk = ~clk;
  end

  function automatic logic [31:0] galois_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  task automatic check_val(input string what, input logic [31:0] got,
                           input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      $display("[ERROR] %0d ns: %s is %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  // option bytes are code and length followed by the value msb first with filler past four
  task automatic push_opt(input byte_t code, input byte_t len, input ipv4_t val);
    int i;
    frame.push_back(code);
    frame.push_back(len);
    for (i = 0; i < len; i++) begin
      frame.push_back((i < 4) ? val[31 - 8*i -: 8] : 8'hee);
    end
  endtask

  task automatic build_frame(input row_t r);
    int    i;
    ipv4_t cookie;
    byte_t long_len;
    frame.delete();
    cookie   = r.bad_cookie ? ~MAGIC_COOKIE : MAGIC_COOKIE;
    long_len = r.junk ? 8'd8 : 8'd4;
    for (i = 0; i < DHCP_HDR_LEN; i++) begin
      frame.push_back(8'(i) ^ 8'h5a);
    end
    for (i = 0; i < 4; i++) begin
      frame[XID_OFS + i]          = r.xid[31 - 8*i -: 8];
      frame[YIADDR_OFS + i]       = r.yiaddr[31 - 8*i -: 8];
      frame[DHCP_HDR_LEN - 4 + i] = cookie[31 - 8*i -: 8];
    end
    // pads, an unknown option and a zero length one ahead of the real options
    if (r.junk) begin
      frame.push_back(OPT_PAD);
      push_opt(8'd12, 8'd6, 32'h686f7374);
      push_opt(8'd60, 8'd0, '0);
      frame.push_back(OPT_PAD);
    end
    if (r.pres[PRES_MSG_TYPE]) push_opt(OPT_MSG_TYPE, 8'd1, {r.mt, 24'h0});
    if (r.pres[PRES_MASK])     push_opt(OPT_NET_MASK, 8'd4, r.mask);
    if (r.pres[PRES_ROUTER])   push_opt(OPT_ROUTER, long_len, r.router);
    if (r.pres[PRES_DNS])      push_opt(OPT_DNS, long_len, r.dns);
    if (r.pres[PRES_SRV_ID])   push_opt(OPT_SRV_ID, 8'd4, r.srv_id);
    if (r.pres[PRES_LEASE])    push_opt(OPT_LEASE_TIME, 8'd4, r.lease);
    if (!r.trunc) begin
      frame.push_back(OPT_END);
      frame.push_back(OPT_PAD);
      frame.push_back(OPT_PAD);
    end
  endtask

  task automatic send_frame(input row_t r);
    int   i;
    int   waited;
    logic gap;
    build_frame(r);
    if (r.sp == DHCP_SRV_PORT && r.dp == DHCP_CLI_PORT) begin
      exp_q.push_back(r);
    end
    for (i = 0; i < frame.size(); i++) begin
      tx_lfsr = galois_next(tx_lfsr);
      gap     = tx_lfsr[0];
      tx_lfsr = galois_next(tx_lfsr);
      if (gap && tx_lfsr[0]) begin
        in_val = 1'b0;
        repeat (2) @(negedge clk);
      end
      in_dat   = frame[i];
      in_sof   = (i == 0);
      in_eof   = (i == frame.size() - 1);
      src_port = r.sp;
      dst_port = r.dp;
      in_val   = 1'b1;
      waited   = 0;
      while (!in_rdy && waited < WAIT_MAX) begin
        @(negedge clk);
        waited++;
      end
      if (!in_rdy) begin
        $display("timeout: in_rdy stayed low for %0d cycles at %0d ns", WAIT_MAX, $time);
        errors++;
        timed_out = 1'b1;
        in_val    = 1'b0;
        return;
      end
      @(negedge clk);
    end
    in_val = 1'b0;
  endtask

  task automatic take_result();
    row_t e;
    if (exp_q.size() == 0) begin
      $display("unexpected result with xid %h at %0d ns", res_xid, $time);
      errors++;
    end
    else begin
      e = exp_q.pop_front();
      check_val("res_err", res_err, e.bad_cookie | e.trunc);
      check_val("res_msg_type", res_msg_type, e.mt);
      check_val("res_xid", res_xid, e.xid);
      check_val("res_yiaddr", res_yiaddr, e.yiaddr);
      check_val("res_mask", res_mask, e.mask);
      check_val("res_router", res_router, e.router);
      check_val("res_dns", res_dns, e.dns);
      check_val("res_srv_id", res_srv_id, e.srv_id);
      check_val("res_lease", res_lease, e.lease);
      check_val("res_pres", res_pres, e.pres);
    end
  endtask

  task automatic watch_backpressure();
    int waited;
    waited = 0;
    while (in_rdy && waited < WAIT_MAX) begin
      @(negedge clk);
      waited++;
    end
    if (in_rdy) begin
      $display("in_rdy never fell while results were held back");
      errors++;
    end
    repeat (20) @(negedge clk);
    @(posedge clk);
    hold_res = 1'b0;
  endtask

  // result sink drawing res_rdy from the lfsr unless results are held back
  initial begin
    forever begin
      @(negedge clk);
      if (hold_res) begin
        res_rdy = 1'b0;
      end
      else begin
        rx_lfsr = galois_next(rx_lfsr);
        res_rdy = rx_lfsr[0];
      end
      if (res_val && res_rdy) begin
        take_result();
      end
    end
  end

  initial begin
    int r;
    int waited;
    fsm_rst   = 1'b1;
    in_dat    = '0;
    in_val    = 1'b0;
    in_sof    = 1'b0;
    in_eof    = 1'b0;
    src_port  = '0;
    dst_port  = '0;
    res_rdy   = 1'b0;
    hold_res  = 1'b1;
    timed_out = 1'b0;
    errors    = 0;
    checks    = 0;
    tx_lfsr   = 32'h9163;
    rx_lfsr   = 32'h9163;

    // sp, dp, xid, yiaddr, bad cookie, trunc, junk, pres,
    // msg type, mask, router, dns, srv id, lease (absent fields are zero)
    table_rows[0] = '{16'd67, 16'd68, 32'h3903f326, 32'hc0a8010a, 1'b0, 1'b0, 1'b0, 6'h3f,
      8'd2, 32'hffffff00, 32'hc0a80101, 32'h08080808, 32'hc0a80101, 32'd86400};
    table_rows[1] = '{16'd68, 16'd67, 32'h11223344, 32'hc0a8010b, 1'b0, 1'b0, 1'b0, 6'h3f,
      8'd2, 32'hffffff00, 32'hc0a80101, 32'h08080808, 32'hc0a80101, 32'd3600};
    table_rows[2] = '{16'd67, 16'd68, 32'h3903f327, 32'hc0a8010a, 1'b0, 1'b0, 1'b0, 6'h3f,
      8'd5, 32'hffffff00, 32'hc0a80101, 32'h01010101, 32'hc0a80101, 32'd43200};
    table_rows[3] = '{16'd67, 16'd68, 32'h0badf00d, 32'h0a000042, 1'b0, 1'b0, 1'b1, 6'h0f,
      8'd2, 32'hffff0000, 32'h0a000001, 32'h0a000002, 32'h0, 32'd0};
    table_rows[4] = '{16'd67, 16'd68, 32'h5eed5eed, 32'h0a000043, 1'b0, 1'b1, 1'b0, 6'h21,
      8'd5, 32'h0, 32'h0, 32'h0, 32'h0, 32'd7200};
    table_rows[5] = '{16'd67, 16'd68, 32'hcafe0001, 32'h0a000044, 1'b1, 1'b0, 1'b0, 6'h3f,
      8'd2, 32'hffffff80, 32'h0a000081, 32'h0a000082, 32'h0a000081, 32'd600};
    table_rows[6] = '{16'd67, 16'd68, 32'h77770001, 32'hac100005, 1'b0, 1'b0, 1'b0, 6'h3f,
      8'd2, 32'hfffff000, 32'hac100001, 32'hac100002, 32'hac100001, 32'd1800};
    table_rows[7] = '{16'd67, 16'd68, 32'h77770002, 32'hac100006, 1'b0, 1'b0, 1'b0, 6'h15,
      8'd6, 32'h0, 32'hac100001, 32'h0, 32'hac100001, 32'd0};
    table_rows[8] = '{16'd67, 16'd68, 32'h77770003, 32'hac100007, 1'b0, 1'b0, 1'b1, 6'h00,
      8'd0, 32'h0, 32'h0, 32'h0, 32'h0, 32'd0};

    repeat (4) @(negedge clk);
    fsm_rst = 1'b0;
    @(posedge clk);
    hold_res = 1'b0;
    @(negedge clk);

    for (r = 0; r < N_FREE && !timed_out; r++) begin
      send_frame(table_rows[r]);
    end

    // the last rows go in while no result is taken
    if (!timed_out) begin
      @(posedge clk);
      hold_res = 1'b1;
      @(negedge clk);
      fork
        begin
          for (r = N_FREE; r < N_ROWS && !timed_out; r++) begin
            send_frame(table_rows[r]);
          end
        end
        watch_backpressure();
      join
    end

    waited = 0;
    while (exp_q.size() != 0 && waited < WAIT_MAX) begin
      @(negedge clk);
      waited++;
    end
    if (exp_q.size() != 0) begin
      $display("timeout: %0d expected results never arrived", exp_q.size());
      errors++;
    end
    // anything showing up now is a duplicate
    repeat (50) @(negedge clk);

    errors += i_dhcp_rx_top.i_dhcp_opt_parser.i_parser_sva.fail_cnt;
    errors += i_dhcp_rx_top.i_rx_byte_fifo.i_fifo_sva.fail_cnt;
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end
    else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule : dhcp_rx_tb

// File: flist.f
common/udp_rx_pkg.sv
common/dhcp_rx_pkg.sv
hw/udp_port_filter.sv
hw/rx_byte_fifo.sv
dhcp_rx/dhcp_opt_parser.sv
hw/dhcp_rx_top.sv
dv/dhcp_rx_sva.sv
dv/dhcp_rx_tb.sv

// File: hw/dhcp_rx_top.sv
`timescale 1ns/1ps

module dhcp_rx_top (
  input  logic                    clk,
  input  logic                    fsm_rst,
  input  udp_rx_pkg::byte_t       in_dat,
  input  logic                    in_val,
  input  logic                    in_sof,
  input  logic                    in_eof,
  input  udp_rx_pkg::port_t       src_port,
  input  udp_rx_pkg::port_t       dst_port,
  output logic                    in_rdy,
  input  logic                    res_rdy,
  output logic                    res_val,
  output logic                    res_err,
  output dhcp_rx_pkg::msg_type_t  res_msg_type,
  output dhcp_rx_pkg::xid_t       res_xid,
  output dhcp_rx_pkg::ipv4_t      res_yiaddr,
  output dhcp_rx_pkg::ipv4_t      res_mask,
  output dhcp_rx_pkg::ipv4_t      res_router,
  output dhcp_rx_pkg::ipv4_t      res_dns,
  output dhcp_rx_pkg::ipv4_t      res_srv_id,
  output dhcp_rx_pkg::lease_t     res_lease,
  output dhcp_rx_pkg::opt_pres_t  res_pres
);

  import udp_rx_pkg::*;

  // filter to fifo
  byte_t wr_dat;
  logic  wr_sof;
  logic  wr_eof;
  logic  wr_en;
  logic  full;

  // fifo to parser
  byte_t rd_dat;
  logic  rd_sof;
  logic  rd_eof;
  logic  rd_val;
  logic  rd_en;

  udp_port_filter i_udp_port_filter (
    .clk      (clk),
    .fsm_rst  (fsm_rst),
    .in_dat   (in_dat),
    .in_val   (in_val),
    .in_sof   (in_sof),
    .in_eof   (in_eof),
    .src_port (src_port),
    .dst_port (dst_port),
    .in_rdy   (in_rdy),
    .wr_dat   (wr_dat),
    .wr_sof   (wr_sof),
    .wr_eof   (wr_eof),
    .wr_en    (wr_en),
    .full     (full)
  );

  rx_byte_fifo i_rx_byte_fifo (
    .clk     (clk),
    .fsm_rst (fsm_rst),
    .wr_dat  (wr_dat),
    .wr_sof  (wr_sof),
    .wr_eof  (wr_eof),
    .wr_en   (wr_en),
    .full    (full),
    .rd_dat  (rd_dat),
    .rd_sof  (rd_sof),
    .rd_eof  (rd_eof),
    .rd_val  (rd_val),
    .rd_en   (rd_en)
  );

  dhcp_opt_parser i_dhcp_opt_parser (
    .clk          (clk),
    .fsm_rst      (fsm_rst),
    .rd_dat       (rd_dat),
    .rd_sof       (rd_sof),
    .rd_eof       (rd_eof),
    .rd_val       (rd_val),
    .rd_en        (rd_en),
    .res_rdy      (res_rdy),
    .res_val      (res_val),
    .res_err      (res_err),
    .res_msg_type (res_msg_type),
    .res_xid      (res_xid),
    .res_yiaddr   (res_yiaddr),
    .res_mask     (res_mask),
    .res_router   (res_router),
    .res_dns      (res_dns),
    .res_srv_id   (res_srv_id),
    .res_lease    (res_lease),
    .res_pres     (res_pres)
  );

endmodule : dhcp_rx_top

// File: hw/rx_byte_fifo.sv
`timescale 1ns/1ps

module rx_byte_fifo (
  input  logic               clk,
  input  logic               fsm_rst,
  input  udp_rx_pkg::byte_t  wr_dat,
  input  logic               wr_sof,
  input  logic               wr_eof,
  input  logic               wr_en,
  output logic               full,
  output udp_rx_pkg::byte_t  rd_dat,
  output logic               rd_sof,
  output logic               rd_eof,
  output logic               rd_val,
  input  logic               rd_en
);

  import udp_rx_pkg::*;

  fifo_ent_t mem [FIFO_DEPTH];

  fifo_ptr_t wr_ptr;
  fifo_ptr_t rd_ptr;
  fifo_ptr_t fill;

  logic empty;
  logic pop;

  assign fill  = wr_ptr - rd_ptr;
  assign empty = (wr_ptr == rd_ptr);

  // raised one entry early, the filter may still have a write in flight
  assign full = (fill >= FIFO_DEPTH - 1);

  assign pop = rd_en && !empty;

  always_ff @ (posedge clk) begin
    if (fsm_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end
    else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @ (posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr[FIFO_AW-1:0]] <= {wr_sof, wr_eof, wr_dat};
    end
  end

  // first word falls through, head entry is always on the read port
  assign {rd_sof, rd_eof, rd_dat} = mem[rd_ptr[FIFO_AW-1:0]];
  assign rd_val = !empty;

endmodule : rx_byte_fifo

// File: hw/udp_port_filter.sv
`timescale 1ns/1ps

module udp_port_filter (
  input  logic               clk,
  input  logic               fsm_rst,
  input  udp_rx_pkg::byte_t  in_dat,
  input  logic               in_val,
  input  logic               in_sof,
  input  logic               in_eof,
  input  udp_rx_pkg::port_t  src_port,
  input  udp_rx_pkg::port_t  dst_port,
  output logic               in_rdy,
  output udp_rx_pkg::byte_t  wr_dat,
  output logic               wr_sof,
  output logic               wr_eof,
  output logic               wr_en,
  input  logic               full
);

  import dhcp_rx_pkg::*;

  logic beat;
  logic port_hit;
  logic pass_q;
  logic pass_now;

  // the fifo keeps one slot spare for the byte still in the output register
  assign in_rdy = !full;
  assign beat   = in_val && in_rdy;

  // ports are only meaningful on the sof beat
  assign port_hit = (src_port == DHCP_SRV_PORT) && (dst_port == DHCP_CLI_PORT);
  assign pass_now = in_sof ? port_hit : pass_q;

  always_ff @ (posedge clk) begin
    if (fsm_rst) begin
      pass_q <= 1'b0;
      wr_en  <= 1'b0;
    end
    else begin
      wr_en <= beat && pass_now;
      if (beat) begin
        if (in_eof) begin
          pass_q <= 1'b0;
        end
        else if (in_sof) begin
          pass_q <= port_hit;
        end
      end
    end
  end

  // rejected frames still advance the stream, they just never reach the fifo
  always_ff @ (posedge clk) begin
    if (beat) begin
      wr_dat <= in_dat;
      wr_sof <= in_sof;
      wr_eof <= in_eof;
    end
  end

endmodule : udp_port_filter
